/* compile.f */
+incdir+hdl
+incdir+testbench
hdl/fpu_pkg.sv
hdl/fpu_credit_gate.sv
hdl/fpu_op_decode.sv
hdl/fpu_logic_perm_lane.sv
hdl/fpu_compare_lane.sv
hdl/fpu_result_merge.sv
hdl/fpu_unit.sv
testbench/tb_fpu_unit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_fpu_unit
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_fpu_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu reference model for the logic, permute, compare and invalid rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_FPU_MODEL_SVH
`define TB_FPU_MODEL_SVH

function automatic logic single_is_nan(input logic [`FPU_SNGL_W-1:0] x);
  return (x[`FPU_EXP_MSB:`FPU_EXP_LSB] == '1) && (x[`FPU_MANT_W-1:0] != '0);
endfunction

// both zeros map to key 0 and negatives sort below positives
function automatic logic signed [`FPU_SNGL_W:0] order_key(
    input logic [`FPU_SNGL_W-1:0] x);
  logic signed [`FPU_SNGL_W:0] mag;
  mag = $signed({2'b00, x[`FPU_SNGL_W-2:0]});
  return x[`FPU_SNGL_W-1] ? -mag : mag;
endfunction

function automatic logic element_matches(input fpu_op_e op,
    input logic [`FPU_SNGL_W-1:0] x, input logic [`FPU_SNGL_W-1:0] y);
  logic signed [`FPU_SNGL_W:0] kx;
  logic signed [`FPU_SNGL_W:0] ky;
  kx = order_key(x);
  ky = order_key(y);
  // unordered pair
  if (single_is_nan(x) || single_is_nan(y)) return op == FOP_CMPUN;
  case (op)
    FOP_CMPEQ: return kx == ky;
    FOP_CMPLT: return kx < ky;
    FOP_CMPLE: return kx <= ky;
    default:   return 1'b0;
  endcase
endfunction

function automatic logic [`FPU_DATA_W-1:0] model_result(input fpu_op_e op,
    input logic [`FPU_DATA_W-1:0] a, input logic [`FPU_DATA_W-1:0] b);
  logic [`FPU_SNGL_W-1:0] lo;
  logic [`FPU_DATA_W-1:0] mask;
  logic                   hit;
  lo = a[`FPU_SNGL_W-1:0];
  mask = '0;
  case (op)
    FOP_AND:   return a & b;
    FOP_OR:    return a | b;
    FOP_XOR:   return a ^ b;
    FOP_ANDN:  return a & ~b;
    FOP_SWAP:  return {lo, a[`FPU_DATA_W-1:`FPU_SNGL_W]};
    FOP_DUPLO: return {lo, lo};
    default: begin
      // one mask per element
      for (int e = 0; e < `FPU_DATA_W / `FPU_SNGL_W; e++) begin
        hit = element_matches(op, a[e*`FPU_SNGL_W +: `FPU_SNGL_W],
                              b[e*`FPU_SNGL_W +: `FPU_SNGL_W]);
        mask[e*`FPU_SNGL_W +: `FPU_SNGL_W] = {`FPU_SNGL_W{hit}};
      end
      return mask;
    end
  endcase
endfunction

// ordered compare that sees any NaN
function automatic logic invalid_flag(input fpu_op_e op, input logic ordered,
    input logic [`FPU_DATA_W-1:0] a, input logic [`FPU_DATA_W-1:0] b);
  logic nan_seen;
  nan_seen = 1'b0;
  for (int e = 0; e < `FPU_DATA_W / `FPU_SNGL_W; e++) begin
    nan_seen |= single_is_nan(a[e*`FPU_SNGL_W +: `FPU_SNGL_W]);
    nan_seen |= single_is_nan(b[e*`FPU_SNGL_W +: `FPU_SNGL_W]);
  end
  return ordered && nan_seen && (op inside {FOP_CMPEQ, FOP_CMPLT, FOP_CMPLE, FOP_CMPUN});
endfunction

function automatic fpu_exc_e exception_code(input logic flag, input logic inv_en);
  return (flag && inv_en) ? EXC_INVALID : EXC_NONE;
endfunction

`endif

/* testbench/tb_fpu_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu unit testbench with special and random ops through a credit
// consumer, checking results in order and at fixed latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module tb_fpu_unit
  import fpu_pkg::*;
();

  `include "tb_fpu_model.svh"

  localparam int N_RANDOM   = 300;
  // two passes of four compares over all special pairs
  localparam int N_DIRECTED = 2 * 4 * 64;
  localparam int N_OPS      = N_RANDOM + N_DIRECTED + `FPU_CREDITS;
  localparam int TIMEOUT    = N_OPS * `FPU_LATENCY + 200;

  // +0, -0, qnan, -qnan, +inf, -inf, 1.0, -2.0
  localparam logic [`FPU_SNGL_W-1:0] SPECIALS [8] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7fc0_0000, 32'hffc0_0001,
    32'h7f80_0000, 32'hff80_0000, 32'h3f80_0000, 32'hc000_0000
  };

  typedef struct packed {
    logic [`FPU_DATA_W-1:0] data;
    fpu_exc_e               exc;
    logic                   flag;
    int                     cycle;
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  fpu_op_e                in_op;
  logic [`FPU_DATA_W-1:0] in_a;
  logic [`FPU_DATA_W-1:0] in_b;
  logic                   in_ordered;
  logic                   inv_enable;
  logic                   credit_return = 1'b0;
  logic                   ready;
  logic                   out_valid;
  logic [`FPU_DATA_W-1:0] out_data;
  fpu_exc_e               out_exc;
  logic                   flag_invalid;

  integer  seed;
  int      cycle;
  int      model_credits;
  int      buf_cnt;
  int      n_issued;
  int      n_results;
  logic    hold_credits;
  expect_t exp_q[$];

  fpu_unit UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  // holds the op until the edge that accepts it
  task automatic issue_op(input fpu_op_e op, input logic [`FPU_DATA_W-1:0] a,
                          input logic [`FPU_DATA_W-1:0] b, input logic ordered);
    in_valid   <= 1'b1;
    in_op      <= op;
    in_a       <= a;
    in_b       <= b;
    in_ordered <= ordered;
    @(posedge clk);
    while (!ready) @(posedge clk);
  endtask

  // every credit back means nothing left in flight
  task automatic wait_idle();
    in_valid <= 1'b0;
    @(posedge clk);
    while (exp_q.size() != 0 || model_credits != `FPU_CREDITS) @(posedge clk);
  endtask

  function automatic logic [`FPU_SNGL_W-1:0] random_single();
    logic [31:0] r;
    r = $random(seed);
    // about one in four is a special value
    if (r[1:0] == 2'b00) r = SPECIALS[3'($unsigned($random(seed)) % 8)];
    return r;
  endfunction

  exc_needs_flag: assert property (@(posedge clk) disable iff (rst)
    (out_exc == EXC_INVALID) |-> (out_valid && flag_invalid && inv_enable))
    else abort_run("exception code raised without an enabled invalid flag");
  flag_needs_result: assert property (@(posedge clk) disable iff (rst)
    flag_invalid |-> out_valid)
    else abort_run("invalid flag raised with no result");
  ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> ready)
    else abort_run("ready low right after reset");

  always @(posedge clk) begin : monitor
    expect_t due;
    int      held;
    logic    drain;
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) begin
      abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT));
    end
    if (rst) begin
      model_credits <= `FPU_CREDITS;
      buf_cnt       <= 0;
      credit_return <= 1'b0;
    end else begin
      assert (ready == (model_credits != 0))
        else abort_run($sformatf("ERR ready expected %h actual %h", model_credits != 0, ready));
      // oldest outstanding op first
      if (out_valid) begin
        assert (exp_q.size() != 0) else abort_run("result seen with no operation outstanding");
        due = exp_q.pop_front();
        assert (out_data == due.data)
          else abort_run($sformatf("ERR out_data expected %h actual %h", due.data, out_data));
        assert (out_exc == due.exc)
          else abort_run($sformatf("ERR out_exc expected %h actual %h", due.exc, out_exc));
        assert (flag_invalid == due.flag)
          else abort_run($sformatf("ERR flag_invalid expected %h actual %h",
                                   due.flag, flag_invalid));
        assert (cycle == due.cycle + `FPU_LATENCY)
          else abort_run($sformatf("ERR out_valid cycle expected %h actual %h",
                                   due.cycle + `FPU_LATENCY, cycle));
        n_results <= n_results + 1;
      end
      if (in_valid && ready) begin
        due.data  = model_result(in_op, in_a, in_b);
        due.flag  = invalid_flag(in_op, in_ordered, in_a, in_b);
        due.exc   = exception_code(due.flag, inv_enable);
        due.cycle = cycle;
        exp_q.push_back(due);
        n_issued <= n_issued + 1;
      end
      model_credits <= model_credits - int'(in_valid && ready) + int'(credit_return);
      // consumer buffer drained at a random rate
      held = buf_cnt + int'(out_valid);
      assert (held <= `FPU_CREDITS)
        else abort_run("consumer holds more results than credits were consumed");
      drain = (held > 0) && !hold_credits && ($unsigned($random(seed)) % 4 != 0);
      credit_return <= drain;
      buf_cnt       <= held - int'(drain);
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    seed         = 32;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_op        = FOP_AND;
    in_a         = '0;
    in_b         = '0;
    in_ordered   = 1'b0;
    inv_enable   = 1'b0;
    hold_credits = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // use up every credit while the consumer keeps them
    hold_credits <= 1'b1;
    for (int k = 0; k < `FPU_CREDITS; k++) begin
      issue_op(FOP_XOR, {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, 1'b0);
    end
    in_valid <= 1'b0;
    @(posedge clk);
    assert (!ready) else abort_run("ready still high with every credit in use");
    hold_credits <= 1'b0;
    @(posedge clk);
    while (!ready) @(posedge clk);

    // special pairs in both orders with invalid enable off then on
    for (int pass = 0; pass < 2; pass++) begin
      wait_idle();
      inv_enable <= 1'(pass);
      for (int k = 0; k < 4; k++) begin
        for (int i = 0; i < 8; i++) begin
          for (int j = 0; j < 8; j++) begin
            issue_op(fpu_op_e'(FOP_CMPEQ + 4'(k)), {SPECIALS[i], SPECIALS[j]},
                     {SPECIALS[j], SPECIALS[i]}, 1'((i + j + k) % 2));
          end
        end
      end
    end

    for (int n = 0; n < N_RANDOM; n++) begin
      r = $random(seed);
      issue_op(fpu_op_e'(4'($unsigned(r) % 10)), {random_single(), random_single()},
               {random_single(), random_single()}, r[31]);
    end

    wait_idle();
    if (n_issued != N_OPS || n_results != n_issued) begin
      abort_run($sformatf("%0d operations issued and %0d results seen, %0d planned",
                          n_issued, n_results, N_OPS));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hdl/fpu_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu top: credit gate, issue decode, two lanes and result stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_unit import fpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  fpu_op_e                in_op,
  input  logic [`FPU_DATA_W-1:0] in_a,
  input  logic [`FPU_DATA_W-1:0] in_b,
  input  logic                   in_ordered,
  input  logic                   inv_enable,
  input  logic                   credit_return,
  output logic                   ready,
  output logic                   out_valid,
  output logic [`FPU_DATA_W-1:0] out_data,
  output fpu_exc_e               out_exc,
  output logic                   flag_invalid
);

  logic                   issue;
  logic                   logic_en;
  logic                   cmp_en;
  fpu_op_e                op;
  logic                   ordered;
  logic [`FPU_DATA_W-1:0] a;
  logic [`FPU_DATA_W-1:0] b;
  logic                   logic_valid;
  logic [`FPU_DATA_W-1:0] logic_res;
  logic                   cmp_valid;
  logic [`FPU_DATA_W-1:0] cmp_res;
  logic                   cmp_invalid;

  // accepted issue
  assign issue = in_valid & ready;

  fpu_credit_gate u_credit_gate (
    .clk(clk), .rst(rst), .issue(issue), .credit_return(credit_return), .ready(ready)
  );

  fpu_op_decode u_op_decode (
    .clk(clk), .rst(rst), .issue(issue), .in_op(in_op), .in_a(in_a), .in_b(in_b),
    .in_ordered(in_ordered), .logic_en(logic_en), .cmp_en(cmp_en), .op(op),
    .ordered(ordered), .a(a), .b(b)
  );

  fpu_logic_perm_lane u_logic_lane (
    .clk(clk), .rst(rst), .en(logic_en), .op(op), .a(a), .b(b),
    .valid(logic_valid), .res(logic_res)
  );

  fpu_compare_lane u_cmp_lane (
    .clk(clk), .rst(rst), .en(cmp_en), .op(op), .ordered(ordered), .a(a), .b(b),
    .valid(cmp_valid), .res(cmp_res), .invalid(cmp_invalid)
  );

  fpu_result_merge u_merge (
    .clk(clk), .rst(rst), .logic_valid(logic_valid), .logic_res(logic_res),
    .cmp_valid(cmp_valid), .cmp_res(cmp_res), .cmp_invalid(cmp_invalid),
    .inv_enable(inv_enable), .out_valid(out_valid), .out_data(out_data),
    .out_exc(out_exc), .flag_invalid(flag_invalid)
  );

endmodule

`default_nettype wire

/* hdl/fpu_result_merge.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu result stage: picks the valid lane and forms the exception code
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_result_merge import fpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   logic_valid,
  input  logic [`FPU_DATA_W-1:0] logic_res,
  input  logic                   cmp_valid,
  input  logic [`FPU_DATA_W-1:0] cmp_res,
  input  logic                   cmp_invalid,
  input  logic                   inv_enable,
  output logic                   out_valid,
  output logic [`FPU_DATA_W-1:0] out_data,
  output fpu_exc_e               out_exc,
  output logic                   flag_invalid
);

  logic inv_hit;

  // lanes never fire in the same cycle
  assign inv_hit = cmp_valid & cmp_invalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid    <= 1'b0;
      flag_invalid <= 1'b0;
      out_exc      <= EXC_NONE;
    end else begin
      out_valid    <= logic_valid | cmp_valid;
      flag_invalid <= inv_hit;
      out_exc      <= (inv_hit && inv_enable) ? EXC_INVALID : EXC_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (cmp_valid) begin
      out_data <= cmp_res;
    end else if (logic_valid) begin
      out_data <= logic_res;
    end
  end

endmodule

`default_nettype wire

/* hdl/fpu_compare_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu compare lane: packed single compares to per-element masks,
// with invalid detection for ordered compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_compare_lane import fpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  fpu_op_e                op,
  input  logic                   ordered,
  input  logic [`FPU_DATA_W-1:0] a,
  input  logic [`FPU_DATA_W-1:0] b,
  output logic                   valid,
  output logic [`FPU_DATA_W-1:0] res,
  output logic                   invalid
);

  localparam int ELEMS = `FPU_DATA_W / `FPU_SNGL_W;

  logic [ELEMS-1:0] elem_true;
  logic [ELEMS-1:0] elem_nan;

  // exponent all ones and nonzero mantissa
  function automatic logic is_nan(input logic [`FPU_SNGL_W-1:0] x);
    is_nan = (&x[`FPU_EXP_MSB:`FPU_EXP_LSB]) && (|x[`FPU_MANT_W-1:0]);
  endfunction

  // sign-magnitude less-than, +0 and -0 treated as equal
  function automatic logic less_than(input logic [`FPU_SNGL_W-1:0] x,
                                     input logic [`FPU_SNGL_W-1:0] y);
    logic [`FPU_SNGL_W-2:0] mx;
    logic [`FPU_SNGL_W-2:0] my;
    logic                   sx;
    logic                   sy;
    mx = x[`FPU_SNGL_W-2:0];
    my = y[`FPU_SNGL_W-2:0];
    sx = x[`FPU_SNGL_W-1];
    sy = y[`FPU_SNGL_W-1];
    if (mx == '0 && my == '0) begin
      less_than = 1'b0;
    end else if (sx != sy) begin
      less_than = sx;
    end else if (!sx) begin
      less_than = (mx < my);
    end else begin
      less_than = (mx > my);
    end
  endfunction

  for (genvar i = 0; i < ELEMS; i++) begin : g_elem
    logic [`FPU_SNGL_W-1:0] ea;
    logic [`FPU_SNGL_W-1:0] eb;
    logic                   eq;
    logic                   lt;

    assign ea = a[i*`FPU_SNGL_W +: `FPU_SNGL_W];
    assign eb = b[i*`FPU_SNGL_W +: `FPU_SNGL_W];
    assign elem_nan[i] = is_nan(ea) | is_nan(eb);
    // both zeros of either sign count as equal
    assign eq = (ea == eb) || (ea[`FPU_SNGL_W-2:0] == '0 && eb[`FPU_SNGL_W-2:0] == '0);
    assign lt = less_than(ea, eb);

    // unordered pair only satisfies CMPUN
    assign elem_true[i] = (op == FOP_CMPUN) ? elem_nan[i] :
                          ~elem_nan[i] & (((op == FOP_CMPEQ) & eq) |
                                          ((op == FOP_CMPLT) & lt) |
                                          ((op == FOP_CMPLE) & (lt | eq)));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= en;
    end
  end

  // mask and invalid bit leave together
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < ELEMS; i++) begin
        res[i*`FPU_SNGL_W +: `FPU_SNGL_W] <= {`FPU_SNGL_W{elem_true[i]}};
      end
      invalid <= ordered & (|elem_nan);
    end
  end

endmodule

`default_nettype wire

/* hdl/fpu_logic_perm_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu logic/permute lane: 64-bit bitwise ops and single-half shuffles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_logic_perm_lane import fpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  fpu_op_e                op,
  input  logic [`FPU_DATA_W-1:0] a,
  input  logic [`FPU_DATA_W-1:0] b,
  output logic                   valid,
  output logic [`FPU_DATA_W-1:0] res
);

  logic [`FPU_SNGL_W-1:0] a_hi;
  logic [`FPU_SNGL_W-1:0] a_lo;
  logic [`FPU_DATA_W-1:0] res_d;

  assign a_hi = a[`FPU_DATA_W-1:`FPU_SNGL_W];
  assign a_lo = a[`FPU_SNGL_W-1:0];

  always_comb begin
    case (op)
      FOP_AND:   res_d = a & b;
      FOP_OR:    res_d = a | b;
      FOP_XOR:   res_d = a ^ b;
      FOP_ANDN:  res_d = a & ~b;
      // halves exchanged
      FOP_SWAP:  res_d = {a_lo, a_hi};
      FOP_DUPLO: res_d = {a_lo, a_lo};
      default:   res_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      res <= res_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/fpu_op_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu issue stage: registers operands and steers the op to one lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_op_decode import fpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue,
  input  fpu_op_e                in_op,
  input  logic [`FPU_DATA_W-1:0] in_a,
  input  logic [`FPU_DATA_W-1:0] in_b,
  input  logic                   in_ordered,
  output logic                   logic_en,
  output logic                   cmp_en,
  output fpu_op_e                op,
  output logic                   ordered,
  output logic [`FPU_DATA_W-1:0] a,
  output logic [`FPU_DATA_W-1:0] b
);

  logic is_logic;
  logic is_cmp;

  // opcode group
  always_comb begin
    case (in_op)
      FOP_AND, FOP_OR, FOP_XOR, FOP_ANDN, FOP_SWAP, FOP_DUPLO: begin
        is_logic = 1'b1;
        is_cmp   = 1'b0;
      end
      FOP_CMPEQ, FOP_CMPLT, FOP_CMPLE, FOP_CMPUN: begin
        is_logic = 1'b0;
        is_cmp   = 1'b1;
      end
      default: begin
        is_logic = 1'b0;
        is_cmp   = 1'b0;
      end
    endcase
  end

  // lane enables, one cycle pulse per issue
  always_ff @(posedge clk) begin
    if (rst) begin
      logic_en <= 1'b0;
      cmp_en   <= 1'b0;
    end else begin
      logic_en <= issue & is_logic;
      cmp_en   <= issue & is_cmp;
    end
  end

  // operands and controls held until the next issue
  always_ff @(posedge clk) begin
    if (issue) begin
      op      <= in_op;
      ordered <= in_ordered;
      a       <= in_a;
      b       <= in_b;
    end
  end

endmodule

`default_nettype wire

/* hdl/fpu_credit_gate.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu issue credits: counts free consumer slots, drives ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_credit_gate (
  input  logic clk,
  input  logic rst,
  input  logic issue,
  input  logic credit_return,
  output logic ready
);

  logic [`FPU_CNT_W-1:0] credits;

  // take one per issue, give one back per return, both cancel
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= `FPU_CNT_W'(`FPU_CREDITS);
    end else begin
      case ({issue, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  assign ready = (credits != '0);

endmodule

`default_nettype wire

/* hdl/fpu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu types: opcode and exception code enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fpu_pkg;

  // logic/permute group first, compares after
  typedef enum logic [3:0] {
    FOP_AND   = 4'd0,
    FOP_OR    = 4'd1,
    FOP_XOR   = 4'd2,
    // a and not b
    FOP_ANDN  = 4'd3,
    // exchange the two singles of a
    FOP_SWAP  = 4'd4,
    // low single of a into both halves
    FOP_DUPLO = 4'd5,
    FOP_CMPEQ = 4'd6,
    FOP_CMPLT = 4'd7,
    FOP_CMPLE = 4'd8,
    // true when either side is NaN
    FOP_CMPUN = 4'd9
  } fpu_op_e;

  typedef enum logic [1:0] {
    EXC_NONE    = 2'd0,
    EXC_INVALID = 2'd1
  } fpu_exc_e;

endpackage

`default_nettype wire

/* hdl/fpu_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu shared constants: datapath widths, single-precision fields,
// issue credits and pipeline depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// operand and result width, two packed singles
`define FPU_DATA_W 64

// one single-precision element
`define FPU_SNGL_W 32

// exponent field inside a single
`define FPU_EXP_LSB 23
`define FPU_EXP_MSB 30

// mantissa field, bits below the exponent
`define FPU_MANT_W 23

// credits after reset, matches consumer buffer depth
`define FPU_CREDITS 4

// wide enough to hold FPU_CREDITS
`define FPU_CNT_W 3

// accepted issue to out_valid, in cycles
`define FPU_LATENCY 3

`endif
